/* cache_bank_pkg.sv */
// shared sizes and port types; every size is fixed here, so resizing the bank means editing these values
package cache_bank_pkg;

    // word and line geometry
    localparam int WORD_BITS      = 32;
    localparam int WORD_BYTES     = WORD_BITS / 8;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;
    localparam int LINE_BYTES     = WORD_BYTES * WORDS_PER_LINE;
    localparam int WSEL_BITS      = $clog2(WORDS_PER_LINE);

    // set and tag split of the line address
    localparam int NUM_SETS       = 16;
    localparam int SET_BITS       = $clog2(NUM_SETS);
    localparam int LINE_ADDR_BITS = 12;
    localparam int TAG_BITS       = LINE_ADDR_BITS - SET_BITS;

    // core request identifier, returned unchanged with the response
    localparam int REQ_TAG_BITS   = 4;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_LOOKUP,
        ST_FILL_REQ,
        ST_FILL_WAIT,
        ST_RESPOND,
        ST_WRITE_REQ
    } bank_state_e;

    // core side request, one word per transfer
    typedef struct packed {
        mem_op_e                   op;
        logic [LINE_ADDR_BITS-1:0] line_addr;
        logic [WSEL_BITS-1:0]      wsel;
        logic [WORD_BYTES-1:0]     byteen;
        logic [WORD_BITS-1:0]      data;
        logic [REQ_TAG_BITS-1:0]   tag;
    } core_req_t;

    // read responses only, writes are not acknowledged
    typedef struct packed {
        logic [WORD_BITS-1:0]    data;
        logic [REQ_TAG_BITS-1:0] tag;
    } core_rsp_t;

    // memory side request, always a full line with a byte mask
    typedef struct packed {
        mem_op_e                   op;
        logic [LINE_ADDR_BITS-1:0] line_addr;
        logic [LINE_BYTES-1:0]     byteen;
        logic [LINE_BITS-1:0]      data;
    } mem_req_t;

endpackage

/* set_sweep_counter.sv */
// walks every set once after reset; wraps back to zero and then idles until enable rises again
`timescale 1ns/10ps

module set_sweep_counter import cache_bank_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                enable,
    output logic [SET_BITS-1:0] set_idx,
    output logic                last
);

    logic [SET_BITS-1:0] count_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (enable) begin
            // natural wrap brings it back to zero after the final set
            count_q <= count_q + 1'b1;
        end
    end

    assign set_idx = count_q;

    // high only in the cycle that clears the final set
    assign last = enable && (count_q == SET_BITS'(NUM_SETS - 1));

endmodule

/* tag_store.sv */
// direct-mapped tag array; hit is combinational from the lookup address, writes land on the next edge
`timescale 1ns/10ps

module tag_store import cache_bank_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clear,
    input  logic [SET_BITS-1:0]       clear_set,
    input  logic                      write,
    input  logic [LINE_ADDR_BITS-1:0] write_addr,
    input  logic [LINE_ADDR_BITS-1:0] lookup_addr,
    output logic                      hit
);

    logic [NUM_SETS-1:0] valid_q;
    logic [TAG_BITS-1:0] tags_q [NUM_SETS];

    logic [SET_BITS-1:0] write_set;
    logic [TAG_BITS-1:0] write_tag;
    logic [SET_BITS-1:0] lookup_set;
    logic [TAG_BITS-1:0] lookup_tag;

    // low bits pick the set, the rest is the tag
    assign write_set  = write_addr[SET_BITS-1:0];
    assign write_tag  = write_addr[LINE_ADDR_BITS-1:SET_BITS];
    assign lookup_set = lookup_addr[SET_BITS-1:0];
    assign lookup_tag = lookup_addr[LINE_ADDR_BITS-1:SET_BITS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            if (clear) begin
                valid_q[clear_set] <= 1'b0;
            end
            if (write) begin
                valid_q[write_set] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            tags_q[write_set] <= write_tag;
        end
    end

    assign hit = valid_q[lookup_set] && (tags_q[lookup_set] == lookup_tag);

endmodule

/* data_store.sv */
// line storage without reset; contents only mean something where the tag store holds a valid bit
`timescale 1ns/10ps

module data_store import cache_bank_pkg::*; (
    input  logic                  clk,

    // full line fill from memory
    input  logic                  fill,
    input  logic [SET_BITS-1:0]   fill_set,
    input  logic [LINE_BITS-1:0]  fill_line,

    // byte-masked update of one word
    input  logic                  word_write,
    input  logic [SET_BITS-1:0]   write_set,
    input  logic [WSEL_BITS-1:0]  write_wsel,
    input  logic [WORD_BYTES-1:0] write_byteen,
    input  logic [WORD_BITS-1:0]  write_word,

    // combinational word read
    input  logic [SET_BITS-1:0]   read_set,
    input  logic [WSEL_BITS-1:0]  read_wsel,
    output logic [WORD_BITS-1:0]  read_word
);

    logic [WORDS_PER_LINE-1:0][WORD_BITS-1:0] lines_q [NUM_SETS];

    // old word with the enabled bytes replaced
    logic [WORD_BITS-1:0] merged_word;

    always_comb begin
        merged_word = lines_q[write_set][write_wsel];
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (write_byteen[b]) begin
                merged_word[b*8 +: 8] = write_word[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            lines_q[fill_set] <= fill_line;
        end else if (word_write) begin
            // the controller never asks for both in one cycle
            lines_q[write_set][write_wsel] <= merged_word;
        end
    end

    assign read_word = lines_q[read_set][read_wsel];

endmodule

/* bank_ctrl.sv */
// blocking controller, one request in flight; writes go through to memory and never allocate
`timescale 1ns/10ps

module bank_ctrl import cache_bank_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,

    // core request
    input  logic                      core_req_valid,
    output logic                      core_req_ready,
    input  core_req_t                 core_req,

    // core response
    output logic                      core_rsp_valid,
    input  logic                      core_rsp_ready,
    output core_rsp_t                 core_rsp,

    // memory request
    output logic                      mem_req_valid,
    input  logic                      mem_req_ready,
    output mem_req_t                  mem_req,

    // memory response
    input  logic                      mem_rsp_valid,
    output logic                      mem_rsp_ready,
    input  logic [LINE_BITS-1:0]      mem_rsp_data,

    // sweep counter
    output logic                      sweep_enable,
    input  logic                      sweep_last,
    input  logic [SET_BITS-1:0]       sweep_set,

    // tag store
    output logic                      tag_clear,
    output logic [SET_BITS-1:0]       tag_clear_set,
    output logic                      tag_write,
    output logic [LINE_ADDR_BITS-1:0] lookup_addr,
    input  logic                      hit,

    // data store
    output logic                      data_fill,
    output logic [LINE_BITS-1:0]      fill_line,
    output logic                      word_write,
    output logic [SET_BITS-1:0]       store_set,
    output logic [WSEL_BITS-1:0]      store_wsel,
    output logic [WORD_BYTES-1:0]     store_byteen,
    output logic [WORD_BITS-1:0]      store_word,
    input  logic [WORD_BITS-1:0]      read_word
);

    bank_state_e state_q;
    bank_state_e state_d;
    core_req_t   req_q;
    logic        fill_fire;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_INIT;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_INIT: begin
                if (sweep_last) state_d = ST_IDLE;
            end
            ST_IDLE: begin
                if (core_req_valid) state_d = ST_LOOKUP;
            end
            ST_LOOKUP: begin
                // writes go to memory whether they hit or not
                if (req_q.op == OP_WRITE) begin
                    state_d = ST_WRITE_REQ;
                end else if (hit) begin
                    state_d = ST_RESPOND;
                end else begin
                    state_d = ST_FILL_REQ;
                end
            end
            ST_FILL_REQ: begin
                if (mem_req_ready) state_d = ST_FILL_WAIT;
            end
            ST_FILL_WAIT: begin
                if (mem_rsp_valid) state_d = ST_RESPOND;
            end
            ST_RESPOND: begin
                if (core_rsp_ready) state_d = ST_IDLE;
            end
            ST_WRITE_REQ: begin
                if (mem_req_ready) state_d = ST_IDLE;
            end
            default: state_d = ST_INIT;
        endcase
    end

    // request is held here until the bank returns to idle
    always_ff @(posedge clk) begin
        if (core_req_valid && core_req_ready) begin
            req_q <= core_req;
        end
    end

    // handshakes, all decoded from the state register
    assign core_req_ready = (state_q == ST_IDLE);
    assign core_rsp_valid = (state_q == ST_RESPOND);
    assign mem_req_valid  = (state_q == ST_FILL_REQ) || (state_q == ST_WRITE_REQ);
    assign mem_rsp_ready  = (state_q == ST_FILL_WAIT);

    assign core_rsp.data = read_word;
    assign core_rsp.tag  = req_q.tag;

    // reads fetch the whole line, writes place the word at its slot
    always_comb begin
        mem_req.op        = req_q.op;
        mem_req.line_addr = req_q.line_addr;
        mem_req.byteen    = '1;
        mem_req.data      = '0;
        if (req_q.op == OP_WRITE) begin
            mem_req.byteen = '0;
            mem_req.byteen[req_q.wsel*WORD_BYTES +: WORD_BYTES] = req_q.byteen;
            mem_req.data   = {WORDS_PER_LINE{req_q.data}};
        end
    end

    // post-reset sweep clears one valid bit per cycle
    assign sweep_enable  = (state_q == ST_INIT);
    assign tag_clear     = (state_q == ST_INIT);
    assign tag_clear_set = sweep_set;

    assign fill_fire   = (state_q == ST_FILL_WAIT) && mem_rsp_valid;
    assign tag_write   = fill_fire;
    assign data_fill   = fill_fire;
    assign fill_line   = mem_rsp_data;
    assign lookup_addr = req_q.line_addr;

    // a write miss leaves the store alone
    assign word_write   = (state_q == ST_LOOKUP) && (req_q.op == OP_WRITE) && hit;
    assign store_set    = req_q.line_addr[SET_BITS-1:0];
    assign store_wsel   = req_q.wsel;
    assign store_byteen = req_q.byteen;
    assign store_word   = req_q.data;

endmodule

/* cache_bank.sv */
// top of a direct-mapped write-through bank; not ready for requests until the post-reset sweep ends
`timescale 1ns/10ps

module cache_bank import cache_bank_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 core_req_valid,
    output logic                 core_req_ready,
    input  core_req_t            core_req,

    output logic                 core_rsp_valid,
    input  logic                 core_rsp_ready,
    output core_rsp_t            core_rsp,

    output logic                 mem_req_valid,
    input  logic                 mem_req_ready,
    output mem_req_t             mem_req,

    input  logic                 mem_rsp_valid,
    output logic                 mem_rsp_ready,
    input  logic [LINE_BITS-1:0] mem_rsp_data
);

    logic                      sweep_enable;
    logic                      sweep_last;
    logic [SET_BITS-1:0]       sweep_set;
    logic                      tag_clear;
    logic [SET_BITS-1:0]       tag_clear_set;
    logic                      tag_write;
    logic [LINE_ADDR_BITS-1:0] lookup_addr;
    logic                      hit;
    logic                      data_fill;
    logic [LINE_BITS-1:0]      fill_line;
    logic                      word_write;
    logic [SET_BITS-1:0]       store_set;
    logic [WSEL_BITS-1:0]      store_wsel;
    logic [WORD_BYTES-1:0]     store_byteen;
    logic [WORD_BITS-1:0]      store_word;
    logic [WORD_BITS-1:0]      read_word;

    bank_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .core_req       (core_req),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_ready (core_rsp_ready),
        .core_rsp       (core_rsp),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready),
        .mem_rsp_data   (mem_rsp_data),
        .sweep_enable   (sweep_enable),
        .sweep_last     (sweep_last),
        .sweep_set      (sweep_set),
        .tag_clear      (tag_clear),
        .tag_clear_set  (tag_clear_set),
        .tag_write      (tag_write),
        .lookup_addr    (lookup_addr),
        .hit            (hit),
        .data_fill      (data_fill),
        .fill_line      (fill_line),
        .word_write     (word_write),
        .store_set      (store_set),
        .store_wsel     (store_wsel),
        .store_byteen   (store_byteen),
        .store_word     (store_word),
        .read_word      (read_word)
    );

    set_sweep_counter u_sweep (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (sweep_enable),
        .set_idx (sweep_set),
        .last    (sweep_last)
    );

    // fills are tagged with the line address of the request in flight
    tag_store u_tags (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (tag_clear),
        .clear_set   (tag_clear_set),
        .write       (tag_write),
        .write_addr  (lookup_addr),
        .lookup_addr (lookup_addr),
        .hit         (hit)
    );

    // one set address serves fill, word write and read
    data_store u_data (
        .clk          (clk),
        .fill         (data_fill),
        .fill_set     (store_set),
        .fill_line    (fill_line),
        .word_write   (word_write),
        .write_set    (store_set),
        .write_wsel   (store_wsel),
        .write_byteen (store_byteen),
        .write_word   (store_word),
        .read_set     (store_set),
        .read_wsel    (store_wsel),
        .read_word    (read_word)
    );

endmodule

/* tb_cache_bank.sv */
// memory model covers line addresses below NUM_SETS*16 only, so every test address stays in that range
`timescale 1ns/10ps

module tb_cache_bank import cache_bank_pkg::*; ();

    logic                 clk;
    logic                 rst_n;
    logic                 core_req_valid;
    logic                 core_req_ready;
    core_req_t            core_req;
    logic                 core_rsp_valid;
    logic                 core_rsp_ready;
    core_rsp_t            core_rsp;
    logic                 mem_req_valid;
    logic                 mem_req_ready;
    mem_req_t             mem_req;
    logic                 mem_rsp_valid;
    logic                 mem_rsp_ready;
    logic [LINE_BITS-1:0] mem_rsp_data;

    // backing memory and every request it has accepted, in order
    logic [LINE_BITS-1:0] mem_lines [1 << (SET_BITS + 4)];
    mem_req_t             mem_log [$];
    logic                 random_ready;
    int                   seed;
    int                   errors;

    cache_bank uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 40 us, far longer than all tests together
    initial begin
        #40000;
        $display("timeout: the run did not finish within 40 us, %0d errors so far", errors);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [WORD_BITS-1:0] fill_word(input int line, input int w);
        return {8'h5a ^ 8'(line), 6'(line >> 2), 2'(w), 8'(w * 37 + line), 8'(line)};
    endfunction

    function automatic logic [WORD_BITS-1:0] model_word(input logic [LINE_ADDR_BITS-1:0] addr,
                                                       input logic [WSEL_BITS-1:0] wsel);
        return mem_lines[addr[SET_BITS+3:0]][wsel*WORD_BITS +: WORD_BITS];
    endfunction

    // memory side: applies writes, answers reads late, and drives both readies
    initial begin : memory_model
        logic [31:0]          rnd;
        logic [LINE_BITS-1:0] rsp_line;
        logic                 rsp_pending;
        int                   rsp_wait;
        mem_req_t             req;
        logic [SET_BITS+3:0]  idx;
        seed           = 32'h61ae6944;
        mem_req_ready  = 1'b1;
        core_rsp_ready = 1'b1;
        mem_rsp_valid  = 1'b0;
        mem_rsp_data   = '0;
        rsp_pending    = 1'b0;
        rsp_wait       = 0;
        for (int i = 0; i < (1 << (SET_BITS + 4)); i++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                mem_lines[i][w*WORD_BITS +: WORD_BITS] = fill_word(i, w);
            end
        end
        forever begin
            @(posedge clk);
            if (mem_rsp_valid && mem_rsp_ready) begin
                mem_rsp_valid <= 1'b0;
            end
            if (rsp_pending) begin
                if (rsp_wait == 0) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_data  <= rsp_line;
                    rsp_pending = 1'b0;
                end else begin
                    rsp_wait--;
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                req = mem_req;
                idx = req.line_addr[SET_BITS+3:0];
                mem_log.push_back(req);
                if (req.op == OP_WRITE) begin
                    for (int b = 0; b < LINE_BYTES; b++) begin
                        if (req.byteen[b]) begin
                            mem_lines[idx][b*8 +: 8] = req.data[b*8 +: 8];
                        end
                    end
                end else begin
                    rnd         = $random(seed);
                    rsp_line    = mem_lines[idx];
                    rsp_wait    = int'(rnd[1:0]);
                    rsp_pending = 1'b1;
                end
            end
            if (random_ready) begin
                rnd = $random(seed);
                mem_req_ready  <= rnd[0];
                core_rsp_ready <= rnd[1];
            end else begin
                mem_req_ready  <= 1'b1;
                core_rsp_ready <= 1'b1;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [LINE_BITS-1:0] got,
                                   input logic [LINE_BITS-1:0] exp);
        errors++;
        $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("at %0t: %s", $time, what);
    endtask

    // returns at the edge where the bank takes the request
    task automatic send_request(input core_req_t req);
        int waited;
        waited = 0;
        core_req_valid <= 1'b1;
        core_req       <= req;
        do begin
            @(posedge clk);
            waited++;
        end while (!core_req_ready && waited < 100);
        if (!core_req_ready) begin
            report_failure("core request not accepted within 100 cycles");
        end
        core_req_valid <= 1'b0;
    endtask

    task automatic collect_response(output core_rsp_t rsp, output int cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!(core_rsp_valid && core_rsp_ready) && cycles < 100);
        if (!(core_rsp_valid && core_rsp_ready)) begin
            report_failure("no core response within 100 cycles");
        end
        rsp = core_rsp;
    endtask

    // polled on the falling edge, away from the model's own updates
    task automatic wait_mem_requests(input int base);
        int waited;
        waited = 0;
        while (mem_log.size() - base < 1 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (mem_log.size() - base < 1) begin
            report_failure("no memory request within 100 cycles");
        end
        @(posedge clk);
    endtask

    task automatic read_and_check(input logic [LINE_ADDR_BITS-1:0] addr,
                                  input logic [WSEL_BITS-1:0] wsel,
                                  input logic [REQ_TAG_BITS-1:0] tag,
                                  input logic expect_fill,
                                  output int latency);
        core_req_t req;
        core_rsp_t rsp;
        mem_req_t  seen;
        int        base;
        int        fills;
        req           = '0;
        req.op        = OP_READ;
        req.line_addr = addr;
        req.wsel      = wsel;
        req.tag       = tag;
        base = mem_log.size();
        send_request(req);
        collect_response(rsp, latency);
        fills = mem_log.size() - base;
        if (expect_fill && fills != 1) begin
            report_failure($sformatf("read of line %0h made %0d fill requests", addr, fills));
        end
        if (!expect_fill && fills != 0) begin
            report_failure($sformatf("read of cached line %0h went to memory", addr));
        end
        if (fills == 1) begin
            seen = mem_log[base];
            if (seen.op !== OP_READ) begin
                report_mismatch("mem_req.op", LINE_BITS'(seen.op), LINE_BITS'(OP_READ));
            end
            if (seen.line_addr !== addr) begin
                report_mismatch("mem_req.line_addr", LINE_BITS'(seen.line_addr), LINE_BITS'(addr));
            end
            if (seen.byteen !== {LINE_BYTES{1'b1}}) begin
                report_mismatch("mem_req.byteen", LINE_BITS'(seen.byteen),
                                LINE_BITS'({LINE_BYTES{1'b1}}));
            end
            // a fill request carries no data
            if (seen.data !== LINE_BITS'(0)) begin
                report_mismatch("mem_req.data", seen.data, LINE_BITS'(0));
            end
        end
        if (rsp.data !== model_word(addr, wsel)) begin
            report_mismatch("core_rsp.data", LINE_BITS'(rsp.data),
                            LINE_BITS'(model_word(addr, wsel)));
        end
        if (rsp.tag !== tag) begin
            report_mismatch("core_rsp.tag", LINE_BITS'(rsp.tag), LINE_BITS'(tag));
        end
    endtask

    task automatic write_and_check(input logic [LINE_ADDR_BITS-1:0] addr,
                                   input logic [WSEL_BITS-1:0] wsel,
                                   input logic [WORD_BYTES-1:0] byteen,
                                   input logic [WORD_BITS-1:0] data);
        core_req_t             req;
        mem_req_t              seen;
        logic [LINE_BYTES-1:0] exp_mask;
        logic [LINE_BITS-1:0]  exp_data;
        logic [WORD_BITS-1:0]  exp_word;
        int                    base;
        // data in every slot, mask only at the addressed slot
        exp_mask = '0;
        for (int s = 0; s < WORDS_PER_LINE; s++) begin
            exp_data[s*WORD_BITS +: WORD_BITS] = data;
            if (s == int'(wsel)) begin
                exp_mask[s*WORD_BYTES +: WORD_BYTES] = byteen;
            end
        end
        exp_word = model_word(addr, wsel);
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (byteen[b]) begin
                exp_word[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        req           = '0;
        req.op        = OP_WRITE;
        req.line_addr = addr;
        req.wsel      = wsel;
        req.byteen    = byteen;
        req.data      = data;
        req.tag       = 4'hf;
        base = mem_log.size();
        send_request(req);
        wait_mem_requests(base);
        if (core_rsp_valid) begin
            report_failure("write produced a core response");
        end
        if (mem_log.size() - base == 1) begin
            seen = mem_log[base];
            if (seen.op !== OP_WRITE) begin
                report_mismatch("mem_req.op", LINE_BITS'(seen.op), LINE_BITS'(OP_WRITE));
            end
            if (seen.line_addr !== addr) begin
                report_mismatch("mem_req.line_addr", LINE_BITS'(seen.line_addr), LINE_BITS'(addr));
            end
            if (seen.byteen !== exp_mask) begin
                report_mismatch("mem_req.byteen", LINE_BITS'(seen.byteen), LINE_BITS'(exp_mask));
            end
            if (seen.data !== exp_data) begin
                report_mismatch("mem_req.data", seen.data, exp_data);
            end
        end else begin
            report_failure("write did not give exactly one memory request");
        end
        if (model_word(addr, wsel) !== exp_word) begin
            report_mismatch("memory word", LINE_BITS'(model_word(addr, wsel)),
                            LINE_BITS'(exp_word));
        end
    endtask

    task automatic reset_sweep_check();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (core_rsp_valid || mem_req_valid || mem_rsp_ready) begin
                report_failure("handshake output active during the reset sweep");
            end
        end while (!core_req_ready && cycles < NUM_SETS + 2);
        if (!core_req_ready) begin
            report_failure("core_req_ready still low after the reset sweep");
        end else if (cycles <= NUM_SETS) begin
            report_failure("core_req_ready rose before the sweep could finish");
        end
    endtask

    task automatic read_miss_fill();
        int lat;
        read_and_check(12'h023, 2'd1, 4'h5, 1'b1, lat);
    endtask

    task automatic read_hit_latency();
        int lat;
        read_and_check(12'h023, 2'd3, 4'h6, 1'b0, lat);
        if (lat != 2) begin
            report_mismatch("core_rsp_valid latency", LINE_BITS'(lat), LINE_BITS'(2));
        end
    endtask

    task automatic write_hit_update();
        int lat;
        write_and_check(12'h023, 2'd2, 4'b0101, 32'hdeadbeef);
        read_and_check(12'h023, 2'd2, 4'h7, 1'b0, lat);
    endtask

    task automatic write_miss_bypass();
        int lat;
        write_and_check(12'h047, 2'd0, 4'b1110, 32'h13579bdf);
        // the line must still be absent, so this read fills it
        read_and_check(12'h047, 2'd0, 4'h8, 1'b1, lat);
    endtask

    task automatic set_conflict_backpressure();
        int                        lat;
        logic [LINE_ADDR_BITS-1:0] addr;
        random_ready <= 1'b1;
        for (int k = 0; k < 6; k++) begin
            // two tags of set 9 keep evicting each other
            addr = (k % 2 == 0) ? 12'h0a9 : 12'h0c9;
            read_and_check(addr, 2'(k), 4'(k + 9), 1'b1, lat);
        end
        random_ready <= 1'b0;
    endtask

    initial begin
        errors         = 0;
        random_ready   = 1'b0;
        rst_n          = 1'b0;
        core_req_valid = 1'b0;
        core_req       = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        reset_sweep_check();
        read_miss_fill();
        read_hit_latency();
        write_hit_update();
        write_miss_bypass();
        set_conflict_backpressure();
        $display("run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* build.f */
cache_bank_pkg.sv
set_sweep_counter.sv
tag_store.sv
data_store.sv
bank_ctrl.sv
cache_bank.sv
tb_cache_bank.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/10ps
TOP       = tb_cache_bank
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only when the pass line appears in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
